// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: src/accel_ifs.sv
`timescale 1ns/10ps
`default_nettype none

// Activation memory traffic between control unit, PE array and memory
interface act_port_if import accel_pkg::*; ();

  logic                     rd_en;
  logic [ACT_ADDR_SIZE-1:0] rd_addr;
  act_vec_t                 rd_data;  // Valid the cycle after rd_en
  logic                     wr_en;
  logic [ACT_ADDR_SIZE-1:0] wr_addr;
  act_vec_t                 wr_data;

  modport ctrl (output rd_en, output rd_addr, output wr_en, output wr_addr);
  modport pe   (output wr_data);
  modport mem  (input rd_en, input rd_addr, output rd_data,
                input wr_en, input wr_addr, input wr_data);

endinterface

interface pe_ctrl_if import accel_pkg::*; ();

  logic                  clear;
  logic                  mac_en;
  logic [STEP_SIZE-1:0]  step;   // Column of the tile and element of the vector
  logic [SHIFT_SIZE-1:0] shift;

  modport ctrl (output clear, output mac_en, output step, output shift);
  modport pe   (input clear, input mac_en, input step, input shift);

endinterface

`default_nettype wire

// File: src/accel_pkg.sv
`default_nettype none

package accel_pkg;

  localparam int N_DIM_ARRAY           = 4;
  localparam int ACT_DATA_WIDTH        = 8;
  localparam int WEIGHT_DATA_WIDTH     = 8;
  localparam int ACC_WIDTH             = 20; // 16-bit products summed over four steps
  localparam int ACT_ADDR_SIZE         = 6;  // 64 activation vectors
  localparam int WEIGHT_ROW_ADDR_SIZE  = 6;  // Tile index on top, row index below
  localparam int WEIGHT_TILE_ADDR_SIZE = 4;
  localparam int IM_ADDR_SIZE          = 5;  // 32 instructions
  localparam int STEP_SIZE             = $clog2(N_DIM_ARRAY);
  localparam int SHIFT_SIZE            = 4;

  // Saturation bounds of a signed activation
  localparam int ACT_MAX = 2 ** (ACT_DATA_WIDTH - 1) - 1;
  localparam int ACT_MIN = -(2 ** (ACT_DATA_WIDTH - 1));

  typedef logic signed [ACT_DATA_WIDTH-1:0]    act_t;
  typedef act_t        [N_DIM_ARRAY-1:0]       act_vec_t;
  typedef logic signed [WEIGHT_DATA_WIDTH-1:0] weight_t;
  typedef weight_t     [N_DIM_ARRAY-1:0]       weight_row_t;
  typedef weight_row_t [N_DIM_ARRAY-1:0]       weight_tile_t; // Row i feeds PE i

  typedef enum logic [1:0] {
    op_halt   = 2'd0,
    op_matvec = 2'd1 // Codes 2 and 3 decode as halt
  } opcode_t;

  typedef struct packed {
    opcode_t                          opcode;
    logic [ACT_ADDR_SIZE-1:0]         in_addr;
    logic [WEIGHT_TILE_ADDR_SIZE-1:0] w_tile;
    logic [ACT_ADDR_SIZE-1:0]         out_addr;
    logic [SHIFT_SIZE-1:0]            shift;    // Fixed-point position of the result
    logic                             write_l1;
    logic                             write_l2;
    logic [7:0]                       reserved;
  } instr_t;

endpackage

`default_nettype wire

// File: src/activation_memory.sv
`timescale 1ns/10ps
`default_nettype none

module activation_memory
  import accel_pkg::*;
(
  input  logic                     clk,
  act_port_if.mem                  act,
  input  logic                     wr_en_ext,
  input  logic [ACT_ADDR_SIZE-1:0] wr_addr_ext,
  input  act_vec_t                 wr_data_ext,
  input  logic                     rd_en_ext,
  input  logic [ACT_ADDR_SIZE-1:0] rd_addr_ext,
  output act_vec_t                 rd_data_ext
);

  act_vec_t mem [0:2**ACT_ADDR_SIZE-1]; // One full vector per address

  // Single write port, the PE result wins over the loader
  always_ff @(posedge clk)
  begin
    if (act.wr_en)
    begin
      mem[act.wr_addr] <= act.wr_data;
    end
    else if (wr_en_ext)
    begin
      mem[wr_addr_ext] <= wr_data_ext;
    end
  end

  always_ff @(posedge clk)
  begin
    if (act.rd_en)
    begin
      act.rd_data <= mem[act.rd_addr]; // Held until the next internal read
    end
    if (rd_en_ext)
    begin
      rd_data_ext <= mem[rd_addr_ext];
    end
  end

endmodule

`default_nettype wire

// File: src/control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit
  import accel_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             enable,
  input  instr_t                           instruction,
  output logic [IM_ADDR_SIZE-1:0]          pc,
  output logic                             w_rd_en,
  output logic [WEIGHT_TILE_ADDR_SIZE-1:0] w_tile_addr,
  act_port_if.ctrl                         act,
  pe_ctrl_if.ctrl                          pe,
  output logic                             done_layer,
  output logic                             finished_network,
  output logic                             wr_output_enable,
  output logic [31:0]                      wr_output_addr
);

  typedef enum logic [2:0] {
    idle,
    fetch,
    read,
    accumulate,
    write,
    halted
  } state_t;

  state_t               state;
  state_t               next_state;
  logic [STEP_SIZE-1:0] step_cnt;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= idle;
      pc       <= '0;
      step_cnt <= '0;
    end
    else
    begin
      state <= next_state;
      case (state)
        idle, halted:
        begin
          if (enable)
          begin
            pc <= '0; // Every run starts at instruction 0
          end
        end
        read:       step_cnt <= '0;
        accumulate: step_cnt <= step_cnt + 1'b1;
        write:      pc <= pc + 1'b1;
        default:    ;
      endcase
    end
  end

  always_comb
  begin
    next_state = state;
    case (state)
      idle, halted:
      begin
        if (enable)
        begin
          next_state = fetch;
        end
      end
      fetch:
      begin
        // Anything that is not a matvec ends the program
        if (instruction.opcode == op_matvec)
        begin
          next_state = read;
        end
        else
        begin
          next_state = halted;
        end
      end
      read: next_state = accumulate;
      accumulate:
      begin
        if (step_cnt == STEP_SIZE'(N_DIM_ARRAY - 1))
        begin
          next_state = write;
        end
      end
      write:   next_state = fetch;
      default: next_state = idle;
    endcase
  end

  // Operand reads, accumulator clear in the same cycle
  assign act.rd_en   = (state == read);
  assign act.rd_addr = instruction.in_addr;
  assign w_rd_en     = (state == read);
  assign w_tile_addr = instruction.w_tile;
  assign pe.clear    = (state == read);

  assign pe.mac_en = (state == accumulate);
  assign pe.step   = step_cnt;
  assign pe.shift  = instruction.shift;

  // L1 and L2 routing of the finished vector
  assign act.wr_en        = (state == write) && instruction.write_l1;
  assign act.wr_addr      = instruction.out_addr;
  assign wr_output_enable = (state == write) && instruction.write_l2;
  assign wr_output_addr   = 32'(instruction.out_addr);

  assign done_layer       = (state == write);
  assign finished_network = (state == halted); // Cleared by the next enable

endmodule

`default_nettype wire

// File: src/cpu.sv
`timescale 1ns/10ps
`default_nettype none

module cpu
  import accel_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            enable,
  // Loader write ports
  input  logic                            wr_en_ext_im,
  input  logic [IM_ADDR_SIZE-1:0]         wr_addr_ext_im,
  input  instr_t                          wr_data_ext_im,
  input  logic                            wr_en_ext_act_mem,
  input  logic [ACT_ADDR_SIZE-1:0]        wr_addr_ext_act_mem,
  input  act_vec_t                        wr_data_ext_act_mem,
  input  logic                            wr_en_ext_w,
  input  logic [WEIGHT_ROW_ADDR_SIZE-1:0] wr_addr_ext_w,
  input  weight_row_t                     wr_data_ext_w,
  // Result readback
  input  logic                            rd_en_ext_act_mem,
  input  logic [ACT_ADDR_SIZE-1:0]        rd_addr_ext_act_mem,
  output act_vec_t                        rd_data_ext_act_mem,
  // Status and L2 output
  output logic                            done_layer,
  output logic                            finished_network,
  output logic                            wr_output_enable,
  output logic [31:0]                     wr_output_addr,
  output act_vec_t                        wr_output_data
);

  logic [IM_ADDR_SIZE-1:0]          pc;
  instr_t                           instruction;
  logic                             w_rd_en;
  logic [WEIGHT_TILE_ADDR_SIZE-1:0] w_tile_addr;
  weight_tile_t                     tile;

  act_port_if act_bus ();
  pe_ctrl_if  pe_bus ();

  instruction_memory instruction_mem (
    .clk            (clk),
    .wr_en_ext_im   (wr_en_ext_im),
    .wr_addr_ext_im (wr_addr_ext_im),
    .wr_data_ext_im (wr_data_ext_im),
    .pc             (pc),
    .instruction    (instruction)
  );

  control_unit control (
    .clk              (clk),
    .rst              (rst),
    .enable           (enable),
    .instruction      (instruction),
    .pc               (pc),
    .w_rd_en          (w_rd_en),
    .w_tile_addr      (w_tile_addr),
    .act              (act_bus.ctrl),
    .pe               (pe_bus.ctrl),
    .done_layer       (done_layer),
    .finished_network (finished_network),
    .wr_output_enable (wr_output_enable),
    .wr_output_addr   (wr_output_addr)
  );

  activation_memory act_mem (
    .clk         (clk),
    .act         (act_bus.mem),
    .wr_en_ext   (wr_en_ext_act_mem),
    .wr_addr_ext (wr_addr_ext_act_mem),
    .wr_data_ext (wr_data_ext_act_mem),
    .rd_en_ext   (rd_en_ext_act_mem),
    .rd_addr_ext (rd_addr_ext_act_mem),
    .rd_data_ext (rd_data_ext_act_mem)
  );

  weight_memory weight_mem (
    .clk          (clk),
    .wr_en_ext    (wr_en_ext_w),
    .wr_addr_ext  (wr_addr_ext_w),
    .wr_data_ext  (wr_data_ext_w),
    .rd_en        (w_rd_en),
    .rd_tile_addr (w_tile_addr),
    .tile         (tile)
  );

  pe_array pes (
    .clk    (clk),
    .rst    (rst),
    .ctrl   (pe_bus.pe),
    .act_in (act_bus.rd_data),
    .tile   (tile),
    .act    (act_bus.pe)
  );

  assign wr_output_data = act_bus.wr_data; // Same vector goes to L1 and L2

endmodule

`default_nettype wire

// File: src/instruction_memory.sv
`timescale 1ns/10ps
`default_nettype none

module instruction_memory
  import accel_pkg::*;
(
  input  logic                    clk,
  input  logic                    wr_en_ext_im,
  input  logic [IM_ADDR_SIZE-1:0] wr_addr_ext_im,
  input  instr_t                  wr_data_ext_im,
  input  logic [IM_ADDR_SIZE-1:0] pc,
  output instr_t                  instruction
);

  instr_t mem [0:2**IM_ADDR_SIZE-1];

  // Loaded only while the processor is idle
  always_ff @(posedge clk)
  begin
    if (wr_en_ext_im)
    begin
      mem[wr_addr_ext_im] <= wr_data_ext_im;
    end
  end

  assign instruction = mem[pc]; // Asynchronous fetch

endmodule

`default_nettype wire

// File: src/pe_array.sv
`timescale 1ns/10ps
`default_nettype none

module pe_array
  import accel_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  pe_ctrl_if.pe        ctrl,
  input  act_vec_t     act_in,
  input  weight_tile_t tile,
  act_port_if.pe       act
);

  logic signed [ACC_WIDTH-1:0]                       acc     [N_DIM_ARRAY];
  logic signed [ACT_DATA_WIDTH+WEIGHT_DATA_WIDTH-1:0] prod    [N_DIM_ARRAY];
  logic signed [ACC_WIDTH-1:0]                       shifted [N_DIM_ARRAY];

  // Full-precision product of weight[i][step] and act[step]
  always_comb
  begin
    for (int i = 0; i < N_DIM_ARRAY; i++)
    begin
      prod[i] = (ACT_DATA_WIDTH + WEIGHT_DATA_WIDTH)'(tile[i][ctrl.step]) *
                (ACT_DATA_WIDTH + WEIGHT_DATA_WIDTH)'(act_in[ctrl.step]);
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < N_DIM_ARRAY; i++)
    begin
      if (rst || ctrl.clear)
      begin
        acc[i] <= '0;
      end
      else if (ctrl.mac_en)
      begin
        acc[i] <= acc[i] + ACC_WIDTH'(prod[i]);
      end
    end
  end

  // Back to activation precision
  always_comb
  begin
    for (int i = 0; i < N_DIM_ARRAY; i++)
    begin
      shifted[i] = acc[i] >>> ctrl.shift; // Arithmetic, keeps the sign
      if (shifted[i] > ACC_WIDTH'(ACT_MAX))
      begin
        act.wr_data[i] = ACT_DATA_WIDTH'(ACT_MAX);
      end
      else if (shifted[i] < ACC_WIDTH'(ACT_MIN))
      begin
        act.wr_data[i] = ACT_DATA_WIDTH'(ACT_MIN);
      end
      else
      begin
        act.wr_data[i] = shifted[i][ACT_DATA_WIDTH-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/weight_memory.sv
`timescale 1ns/10ps
`default_nettype none

module weight_memory
  import accel_pkg::*;
(
  input  logic                             clk,
  input  logic                             wr_en_ext,
  input  logic [WEIGHT_ROW_ADDR_SIZE-1:0]  wr_addr_ext,
  input  weight_row_t                      wr_data_ext,
  input  logic                             rd_en,
  input  logic [WEIGHT_TILE_ADDR_SIZE-1:0] rd_tile_addr,
  output weight_tile_t                     tile
);

  weight_tile_t mem [0:2**WEIGHT_TILE_ADDR_SIZE-1];

  logic [WEIGHT_TILE_ADDR_SIZE-1:0]                      wr_tile;
  logic [WEIGHT_ROW_ADDR_SIZE-WEIGHT_TILE_ADDR_SIZE-1:0] wr_row;

  assign wr_tile = wr_addr_ext[WEIGHT_ROW_ADDR_SIZE-1 -: WEIGHT_TILE_ADDR_SIZE];
  assign wr_row  = wr_addr_ext[WEIGHT_ROW_ADDR_SIZE-WEIGHT_TILE_ADDR_SIZE-1:0];

  always_ff @(posedge clk)
  begin
    if (wr_en_ext)
    begin
      mem[wr_tile][wr_row] <= wr_data_ext; // One row per strobe
    end
    if (rd_en)
    begin
      tile <= mem[rd_tile_addr]; // Whole 4x4 tile at once
    end
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+testbench
src/accel_pkg.sv
src/accel_ifs.sv
src/instruction_memory.sv
src/control_unit.sv
src/activation_memory.sv
src/weight_memory.sv
src/pe_array.sv
src/cpu.sv
testbench/tb_cpu.sv

// File: testbench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Signed 8-bit saturation of a full precision result
function automatic act_t clip_to_byte(input int value);
  if (value > 127)
  begin
    return 8'sd127;
  end
  if (value < -128)
  begin
    return -8'sd128;
  end
  return 8'(value);
endfunction

// Output i is the dot product of weight row i with the activation vector
function automatic act_vec_t matvec_model(input weight_tile_t w, input act_vec_t a,
                                          input int shift);
  act_vec_t result;
  int       sum;
  for (int i = 0; i < 4; i++)
  begin
    sum = 0;
    for (int j = 0; j < 4; j++)
    begin
      sum += int'(w[i][j]) * int'(a[j]); // Exact, no intermediate width limit
    end
    result[i] = clip_to_byte(sum >>> shift);
  end
  return result;
endfunction

`endif

// File: testbench/tb_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu
  import accel_pkg::*;
();

  localparam int unsigned SEED = 32'h6002_7cc0;
  localparam int WATCHDOG_CYCLES = 3000; // Load, two runs and readback take a few hundred
  localparam int N_PROG = 6;

  `include "tb_ref_model.svh"

  logic clk;
  logic rst;
  logic enable;
  logic wr_en_ext_im;
  logic [IM_ADDR_SIZE-1:0] wr_addr_ext_im;
  instr_t wr_data_ext_im;
  logic wr_en_ext_act_mem;
  logic [ACT_ADDR_SIZE-1:0] wr_addr_ext_act_mem;
  act_vec_t wr_data_ext_act_mem;
  logic wr_en_ext_w;
  logic [WEIGHT_ROW_ADDR_SIZE-1:0] wr_addr_ext_w;
  weight_row_t wr_data_ext_w;
  logic rd_en_ext_act_mem;
  logic [ACT_ADDR_SIZE-1:0] rd_addr_ext_act_mem;
  act_vec_t rd_data_ext_act_mem;
  logic done_layer;
  logic finished_network;
  logic wr_output_enable;
  logic [31:0] wr_output_addr;
  act_vec_t wr_output_data;

  int checks = 0;
  int errors = 0;
  int done_count = 0;
  act_vec_t act_model [64];  // Expected L1 contents
  weight_tile_t tile_model [16];
  instr_t prog [N_PROG];
  logic [31:0] l2_addr_q [$]; // Observed L2 writes
  act_vec_t l2_data_q [$];
  logic [31:0] exp_l2_addr [$];
  act_vec_t exp_l2_data [$];

  cpu DUT (.*);

  always #50 clk = ~clk;

  task automatic report_error(input string msg);
    errors++;
    $display("error %0t: %s", $time, msg);
  endtask

  task automatic check_vector(input string what, input act_vec_t got, input act_vec_t exp);
    checks++;
    assert (got === exp)
    else report_error($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic check_value(input string what, input int got, input int exp);
    checks++;
    assert (got == exp)
    else report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
  endtask

  task automatic load_instruction(input int addr, input instr_t word);
    @(posedge clk);
    wr_en_ext_im   <= 1'b1;
    wr_addr_ext_im <= IM_ADDR_SIZE'(addr);
    wr_data_ext_im <= word;
    @(posedge clk);
    wr_en_ext_im <= 1'b0;
  endtask

  task automatic load_activation(input int addr, input act_vec_t vec);
    @(posedge clk);
    wr_en_ext_act_mem   <= 1'b1;
    wr_addr_ext_act_mem <= ACT_ADDR_SIZE'(addr);
    wr_data_ext_act_mem <= vec;
    @(posedge clk);
    wr_en_ext_act_mem <= 1'b0;
  endtask

  task automatic load_weight_row(input int tile, input int row, input weight_row_t data);
    @(posedge clk);
    wr_en_ext_w   <= 1'b1;
    wr_addr_ext_w <= {4'(tile), 2'(row)}; // Tile on top, row below
    wr_data_ext_w <= data;
    @(posedge clk);
    wr_en_ext_w <= 1'b0;
  endtask

  task automatic read_activation(input int addr, output act_vec_t data);
    @(posedge clk);
    rd_en_ext_act_mem   <= 1'b1;
    rd_addr_ext_act_mem <= ACT_ADDR_SIZE'(addr);
    @(posedge clk);
    rd_en_ext_act_mem <= 1'b0;
    @(negedge clk);
    data = rd_data_ext_act_mem; // Registered on the edge that saw rd_en
  endtask

  task automatic start_program();
    @(posedge clk);
    enable <= 1'b1;
    @(posedge clk);
    enable <= 1'b0;
    @(negedge clk);
  endtask

  function automatic instr_t make_matvec(input int in_a, input int tile, input int out_a,
                                         input int shift, input bit l1, input bit l2);
    return {2'd1, 6'(in_a), 4'(tile), 6'(out_a), 4'(shift), l1, l2, 8'h00};
  endfunction

  // Count layer ends and capture every L2 write
  always @(negedge clk)
  begin
    if (!rst && done_layer)
    begin
      done_count++;
    end
    if (!rst && wr_output_enable)
    begin
      l2_addr_q.push_back(wr_output_addr);
      l2_data_q.push_back(wr_output_data);
    end
  end

  l2_inside_done: assert property (@(posedge clk) disable iff (rst)
                                   wr_output_enable |-> done_layer)
    else report_error("wr_output_enable high without done_layer");
  done_one_cycle: assert property (@(posedge clk) disable iff (rst)
                                   done_layer |=> !done_layer)
    else report_error("done_layer longer than one cycle");
  finished_holds: assert property (@(posedge clk) disable iff (rst)
                                   finished_network && !enable |=> finished_network)
    else report_error("finished_network dropped without enable");

  initial
  begin
    act_vec_t got;
    int       mag;
    int       exp_done;
    int       done_before;
    int       l2_before;
    void'($urandom(SEED));
    clk = 1'b0;
    rst = 1'b1;
    enable = 1'b0;
    wr_en_ext_im = 1'b0;
    wr_addr_ext_im = '0;
    wr_data_ext_im = '0;
    wr_en_ext_act_mem = 1'b0;
    wr_addr_ext_act_mem = '0;
    wr_data_ext_act_mem = '0;
    wr_en_ext_w = 1'b0;
    wr_addr_ext_w = '0;
    wr_data_ext_w = '0;
    rd_en_ext_act_mem = 1'b0;
    rd_addr_ext_act_mem = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    checks++;
    assert (!done_layer && !finished_network && !wr_output_enable)
    else report_error("status outputs not low after reset");

    for (int i = 0; i < 4; i++)
    begin
      act_model[i] = $urandom;
      load_activation(i, act_model[i]);
    end
    act_model[21] = $urandom; // Target of the L2-only layer, must stay
    load_activation(21, act_model[21]);
    for (int t = 0; t < 2; t++)
    begin
      tile_model[t] = {$urandom, $urandom, $urandom, $urandom};
    end
    for (int r = 0; r < 4; r++)
    begin
      for (int c = 0; c < 4; c++)
      begin
        mag = $urandom_range(127, 100); // Near full scale to force clipping
        tile_model[2][r][c] = (($urandom % 2) == 1) ? 8'(mag) : 8'(-mag);
      end
    end
    for (int t = 0; t < 3; t++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        load_weight_row(t, r, tile_model[t][r]);
      end
    end
    foreach (act_model[i])
    begin
      if (i < 4 || i == 21)
      begin
        read_activation(i, got);
        check_vector($sformatf("readback of address %0d", i), got, act_model[i]);
      end
    end

    prog[0] = make_matvec(0, 0, 20, 6, 1'b1, 1'b0);
    prog[1] = make_matvec(1, 1, 21, 5, 1'b0, 1'b1);
    prog[2] = make_matvec(2, 2, 22, 0, 1'b1, 1'b1);
    prog[3] = make_matvec(3, 2, 23, 4, 1'b1, 1'b0);
    prog[4] = make_matvec(20, 1, 24, 3, 1'b1, 1'b0); // Consumes the result of layer 0
    prog[5] = '0;
    for (int k = 0; k < N_PROG; k++)
    begin
      load_instruction(k, prog[k]);
    end

    exp_done = 0;
    for (int k = 0; k < N_PROG; k++)
    begin
      if (prog[k].opcode != op_matvec)
      begin
        break;
      end
      got = matvec_model(tile_model[prog[k].w_tile], act_model[prog[k].in_addr],
                         int'(prog[k].shift));
      exp_done++;
      if (prog[k].write_l2)
      begin
        exp_l2_addr.push_back(32'(prog[k].out_addr));
        exp_l2_data.push_back(got);
      end
      if (prog[k].write_l1)
      begin
        act_model[prog[k].out_addr] = got;
      end
    end

    // Second pass reruns the same program and must give the same results
    for (int run = 0; run < 2; run++)
    begin
      done_before = done_count;
      l2_before = l2_data_q.size();
      start_program();
      check_value("finished_network after enable", int'(finished_network), 0);
      while (!finished_network)
      begin
        @(negedge clk);
      end
      repeat (3) @(negedge clk);
      check_value("finished_network after halt", int'(finished_network), 1);
      check_value("done_layer pulses", done_count - done_before, exp_done);
      check_value("L2 writes", l2_data_q.size() - l2_before, exp_l2_data.size());
      for (int k = 0; k < exp_l2_data.size(); k++)
      begin
        check_value("L2 address", int'(l2_addr_q[l2_before + k]), int'(exp_l2_addr[k]));
        check_vector("L2 data", l2_data_q[l2_before + k], exp_l2_data[k]);
      end
      for (int a = 20; a < 25; a++)
      begin
        read_activation(a, got);
        check_vector($sformatf("L1 address %0d", a), got, act_model[a]);
      end
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("Simulation completed successfully");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the program did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
